/* src/lpf_pkg.sv */
// Biquad coefficient fixed-point package
`default_nettype none

package lpf_pkg;

    // Word format is Q2.16
    localparam int WORD_W = 18;
    localparam int FRAC_W = 16;

    typedef logic signed [WORD_W-1:0] word_t;

    // ----------------------------------------------------------------------
    // Fixed-point constants
    // ----------------------------------------------------------------------
    localparam word_t Q_ONE     = word_t'(65536);
    localparam word_t Q_NEG_ONE = word_t'(-65536);
    localparam word_t Q_HALF    = word_t'(32768);
    // Most negative word, also the low saturation limit
    localparam word_t Q_NEG_TWO = word_t'(-131072);

    // Taylor series factors
    localparam word_t C_INV6     = word_t'(-10923);
    localparam word_t C_INV120   = word_t'(546);
    localparam word_t C_NEG_HALF = word_t'(-32768);
    localparam word_t C_INV24    = word_t'(2731);

    // Multiply-add slice operations
    typedef enum logic {
        OP_MUL,
        OP_MAC
    } mac_op_t;

endpackage

`default_nettype wire

/* src/dsp_bus_if.sv */
// Shared multiply-add slice bus
`timescale 1ns/10ps
`default_nettype none

interface dsp_bus_if
    import lpf_pkg::*;
();

    // Request side, owner to slice
    logic    req_valid;
    mac_op_t op;
    word_t   a;
    word_t   b;
    word_t   c;

    // Result side, three cycles later
    logic  res_valid;
    word_t res;

    modport owner (
        output req_valid, op, a, b, c,
        input  res_valid, res
    );

    modport slice (
        input  req_valid, op, a, b, c,
        output res_valid, res
    );

endinterface

`default_nettype wire

/* src/coef_bus_if.sv */
// Coefficient set handoff bus
`timescale 1ns/10ps
`default_nettype none

interface coef_bus_if
    import lpf_pkg::*;
();

    // Set moves when valid and ready are both high
    logic  valid;
    logic  ready;
    word_t b0;
    word_t b1;
    word_t b2;
    word_t a0;
    word_t a1;
    word_t a2;

    modport engine (
        output valid, b0, b1, b2, a0, a1, a2,
        input  ready
    );

    modport sender (
        input  valid, b0, b1, b2, a0, a1, a2,
        output ready
    );

endinterface

`default_nettype wire

/* src/calc_request_queue.sv */
// Credit-controlled request FIFO
`timescale 1ns/10ps
`default_nettype none

module calc_request_queue
    import lpf_pkg::*;
#(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic  clk,
    input  logic  reset,
    input  logic  push,
    input  word_t push_omega0,
    input  word_t push_inv_2q,
    input  logic  pop,
    output logic  empty,
    output word_t head_omega0,
    output word_t head_inv_2q,
    output logic  credit
);

    localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);
    localparam logic [PTR_W-1:0] LAST_SLOT = PTR_W'(QUEUE_DEPTH - 1);

    // Storage, one word pair per slot
    word_t omega0_mem [QUEUE_DEPTH];
    word_t inv_2q_mem [QUEUE_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_pop;

    assign empty       = (count == '0);
    // Pop on an empty queue is ignored
    assign do_pop      = pop && !empty;
    assign head_omega0 = omega0_mem[rd_ptr];
    assign head_inv_2q = inv_2q_mem[rd_ptr];

    // Write port
    always_ff @(posedge clk) begin
        if (push) begin
            omega0_mem[wr_ptr] <= push_omega0;
            inv_2q_mem[wr_ptr] <= push_inv_2q;
        end
    end

    // ----------------------------------------------------------------------
    // Pointers, fill level and credit return
    // ----------------------------------------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            credit <= 1'b0;
        end else begin
            // Freed slot goes back upstream as one credit
            credit <= do_pop;
            if (push) begin
                wr_ptr <= (wr_ptr == LAST_SLOT) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == LAST_SLOT) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

/* src/mac_slice.sv */
// Pipelined saturating multiply-add
`timescale 1ns/10ps
`default_nettype none

module mac_slice
    import lpf_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    dsp_bus_if.slice bus
);

    localparam int PROD_W  = 2 * WORD_W;
    localparam int SHIFT_W = PROD_W - FRAC_W;
    localparam int SUM_W   = SHIFT_W + 1;

    // Stage 1, operand register
    logic    s1_valid;
    mac_op_t s1_op;
    word_t   s1_a;
    word_t   s1_b;
    word_t   s1_c;

    // Stage 2, product register
    logic                     s2_valid;
    mac_op_t                  s2_op;
    logic signed [PROD_W-1:0] s2_prod;
    word_t                    s2_c;

    // Stage 3 combinational path
    logic signed [SHIFT_W-1:0] shifted;
    word_t                     addend;
    logic signed [SUM_W-1:0]   sum;
    word_t                     sat;

    // Dropping fraction bits is a floor shift
    assign shifted = s2_prod[PROD_W-1:FRAC_W];
    assign addend  = (s2_op == OP_MAC) ? s2_c : word_t'(0);
    assign sum     = SUM_W'(shifted) + SUM_W'(addend);

    // Clamp to the 18-bit range
    always_comb begin
        if (sum[SUM_W-1:WORD_W-1] == {(SUM_W-WORD_W+1){sum[SUM_W-1]}}) begin
            sat = sum[WORD_W-1:0];
        end else if (sum[SUM_W-1]) begin
            sat = Q_NEG_TWO;
        end else begin
            sat = ~Q_NEG_TWO;
        end
    end

    // ----------------------------------------------------------------------
    // Valid bit travels beside the data
    // ----------------------------------------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            s1_valid      <= 1'b0;
            s2_valid      <= 1'b0;
            bus.res_valid <= 1'b0;
        end else begin
            s1_valid      <= bus.req_valid;
            s2_valid      <= s1_valid;
            bus.res_valid <= s2_valid;
        end
    end

    // Data stages
    always_ff @(posedge clk) begin
        s1_op   <= bus.op;
        s1_a    <= bus.a;
        s1_b    <= bus.b;
        s1_c    <= bus.c;
        s2_op   <= s1_op;
        s2_prod <= s1_a * s1_b;
        s2_c    <= s1_c;
        bus.res <= sat;
    end

endmodule

`default_nettype wire

/* src/taylor_trig.sv */
// Taylor series sine and cosine
`timescale 1ns/10ps
`default_nettype none

module taylor_trig
    import lpf_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     start,
    input  word_t    x,
    output logic     done,
    output word_t    sin_x,
    output word_t    cos_x,
    dsp_bus_if.owner bus
);

    localparam logic [1:0] ST_IDLE  = 2'd0;
    localparam logic [1:0] ST_ISSUE = 2'd1;
    localparam logic [1:0] ST_WAIT  = 2'd2;
    localparam logic [2:0] LAST_STEP = 3'd5;

    logic [1:0] state;
    logic [2:0] step;

    // Angle, its square, and the running Horner term
    word_t x_q;
    word_t x2_q;
    word_t t_q;

    // One request per issue cycle
    assign bus.req_valid = (state == ST_ISSUE);

    // ----------------------------------------------------------------------
    // Operand select per step
    // ----------------------------------------------------------------------
    // Default is the closing Horner step, x2*t + 1
    always_comb begin
        bus.op = OP_MAC;
        bus.a  = x2_q;
        bus.b  = t_q;
        bus.c  = Q_ONE;
        case (step)
            3'd0: begin
                // x squared
                bus.op = OP_MUL;
                bus.a  = x_q;
                bus.b  = x_q;
            end
            3'd1: begin
                bus.b = C_INV120;
                bus.c = C_INV6;
            end
            3'd3: begin
                // sin = x * t2
                bus.op = OP_MUL;
                bus.a  = x_q;
            end
            3'd4: begin
                bus.b = C_INV24;
                bus.c = C_NEG_HALF;
            end
            default: begin
            end
        endcase
    end

    // Sequencer, each step waits for the previous result
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= ST_IDLE;
            step  <= '0;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (start) begin
                        step  <= '0;
                        state <= ST_ISSUE;
                    end
                end
                ST_ISSUE: state <= ST_WAIT;
                ST_WAIT: begin
                    if (bus.res_valid) begin
                        if (step == LAST_STEP) begin
                            done  <= 1'b1;
                            state <= ST_IDLE;
                        end else begin
                            step  <= step + 1'b1;
                            state <= ST_ISSUE;
                        end
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Results land by step; sin and cos hold after done
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && start) begin
            x_q <= x;
        end
        if (state == ST_WAIT && bus.res_valid) begin
            case (step)
                3'd0:    x2_q  <= bus.res;
                3'd3:    sin_x <= bus.res;
                3'd5:    cos_x <= bus.res;
                default: t_q   <= bus.res;
            endcase
        end
    end

endmodule

`default_nettype wire

/* src/lpf_coef_engine.sv */
// Biquad low-pass coefficient engine
`timescale 1ns/10ps
`default_nettype none

module lpf_coef_engine
    import lpf_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       empty,
    input  word_t      omega0,
    input  word_t      inv_2q,
    output logic       pop,
    coef_bus_if.engine coefs
);

    localparam logic [2:0] S_IDLE  = 3'd0;
    localparam logic [2:0] S_TRIG  = 3'd1;
    localparam logic [2:0] S_ISSUE = 3'd2;
    localparam logic [2:0] S_WAIT  = 3'd3;
    localparam logic [2:0] S_HOLD  = 3'd4;
    localparam logic [2:0] LAST_STEP = 3'd5;

    logic [2:0] state;
    logic [2:0] step;
    logic       owner_taylor;

    // Latched damping term and intermediate alpha
    word_t inv_q;
    word_t alpha_q;
    // Coefficient registers, b2 mirrors b0
    word_t b0_q;
    word_t b1_q;
    word_t a0_q;
    word_t a1_q;
    word_t a2_q;

    logic  trig_done;
    word_t trig_sin;
    word_t trig_cos;

    dsp_bus_if local_bus  ();
    dsp_bus_if taylor_bus ();
    dsp_bus_if slice_bus  ();

    // Pop only when idle; the popped angle starts the trig unit at once
    assign pop = (state == S_IDLE) && !empty;

    taylor_trig u_trig (
        .clk   (clk),
        .reset (reset),
        .start (pop),
        .x     (omega0),
        .done  (trig_done),
        .sin_x (trig_sin),
        .cos_x (trig_cos),
        .bus   (taylor_bus.owner)
    );

    mac_slice u_slice (
        .clk   (clk),
        .reset (reset),
        .bus   (slice_bus.slice)
    );

    // ----------------------------------------------------------------------
    // Slice owner multiplexer
    // ----------------------------------------------------------------------
    // Trig unit owns the slice for the whole trig phase
    assign owner_taylor = (state == S_TRIG);

    always_comb begin
        if (owner_taylor) begin
            slice_bus.req_valid = taylor_bus.req_valid;
            slice_bus.op        = taylor_bus.op;
            slice_bus.a         = taylor_bus.a;
            slice_bus.b         = taylor_bus.b;
            slice_bus.c         = taylor_bus.c;
        end else begin
            slice_bus.req_valid = local_bus.req_valid;
            slice_bus.op        = local_bus.op;
            slice_bus.a         = local_bus.a;
            slice_bus.b         = local_bus.b;
            slice_bus.c         = local_bus.c;
        end
    end

    // Results fan out, valid only toward the current owner
    assign taylor_bus.res_valid = slice_bus.res_valid && owner_taylor;
    assign taylor_bus.res       = slice_bus.res;
    assign local_bus.res_valid  = slice_bus.res_valid && !owner_taylor;
    assign local_bus.res        = slice_bus.res;

    // ----------------------------------------------------------------------
    // Local operations
    // ----------------------------------------------------------------------
    assign local_bus.req_valid = (state == S_ISSUE);

    // Default is a2 = alpha * -1 + 1
    always_comb begin
        local_bus.op = OP_MAC;
        local_bus.a  = alpha_q;
        local_bus.b  = Q_NEG_ONE;
        local_bus.c  = Q_ONE;
        case (step)
            3'd0: begin
                // alpha = sin * inv_2q
                local_bus.op = OP_MUL;
                local_bus.a  = trig_sin;
                local_bus.b  = inv_q;
            end
            3'd1: local_bus.a = trig_cos;
            3'd2: begin
                // b0 = b1 / 2
                local_bus.op = OP_MUL;
                local_bus.a  = b1_q;
                local_bus.b  = Q_HALF;
            end
            3'd3: begin
                local_bus.op = OP_MUL;
                local_bus.a  = trig_cos;
                local_bus.b  = Q_NEG_TWO;
            end
            3'd4: local_bus.b = Q_ONE;
            default: begin
            end
        endcase
    end

    // Main FSM
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= S_IDLE;
            step  <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (pop) begin
                        state <= S_TRIG;
                    end
                end
                S_TRIG: begin
                    if (trig_done) begin
                        step  <= '0;
                        state <= S_ISSUE;
                    end
                end
                S_ISSUE: state <= S_WAIT;
                S_WAIT: begin
                    if (local_bus.res_valid) begin
                        step  <= step + 1'b1;
                        state <= (step == LAST_STEP) ? S_HOLD : S_ISSUE;
                    end
                end
                // held until the sender takes the set
                S_HOLD: begin
                    if (coefs.ready) begin
                        state <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // Capture request operand and local results
    always_ff @(posedge clk) begin
        if (pop) begin
            inv_q <= inv_2q;
        end
        if (state == S_WAIT && local_bus.res_valid) begin
            case (step)
                3'd0:    alpha_q <= local_bus.res;
                3'd1:    b1_q    <= local_bus.res;
                3'd2:    b0_q    <= local_bus.res;
                3'd3:    a1_q    <= local_bus.res;
                3'd4:    a0_q    <= local_bus.res;
                default: a2_q    <= local_bus.res;
            endcase
        end
    end

    assign coefs.valid = (state == S_HOLD);
    assign coefs.b0    = b0_q;
    assign coefs.b1    = b1_q;
    assign coefs.b2    = b0_q;
    assign coefs.a0    = a0_q;
    assign coefs.a1    = a1_q;
    assign coefs.a2    = a2_q;

endmodule

`default_nettype wire

/* src/coef_credit_sender.sv */
// Credit-controlled coefficient sender
`timescale 1ns/10ps
`default_nettype none

module coef_credit_sender
    import lpf_pkg::*;
#(
    parameter int OUT_CREDITS = 2
) (
    input  logic       clk,
    input  logic       reset,
    coef_bus_if.sender coefs,
    input  logic       coef_credit,
    output logic       coef_valid,
    output word_t      b0,
    output word_t      b1,
    output word_t      b2,
    output word_t      a0,
    output word_t      a1,
    output word_t      a2
);

    localparam int CRED_W = $clog2(OUT_CREDITS + 1);
    localparam logic [CRED_W-1:0] CRED_MAX = CRED_W'(OUT_CREDITS);

    logic [CRED_W-1:0] credits;
    logic              accept;

    // Take a set only with credit left and the output register free
    assign coefs.ready = (credits != '0) && !coef_valid;
    assign accept      = coefs.valid && coefs.ready;

    // ----------------------------------------------------------------------
    // Credit counter
    // ----------------------------------------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            credits    <= CRED_MAX;
            coef_valid <= 1'b0;
        end else begin
            coef_valid <= accept;
            // Send and return in one cycle cancel
            case ({coef_valid, coef_credit})
                2'b10: credits <= credits - 1'b1;
                2'b01: begin
                    if (credits != CRED_MAX) begin
                        credits <= credits + 1'b1;
                    end
                end
                default: credits <= credits;
            endcase
        end
    end

    // Output register, loaded on accept
    always_ff @(posedge clk) begin
        if (accept) begin
            b0 <= coefs.b0;
            b1 <= coefs.b1;
            b2 <= coefs.b2;
            a0 <= coefs.a0;
            a1 <= coefs.a1;
            a2 <= coefs.a2;
        end
    end

endmodule

`default_nettype wire

/* src/lpf_coef_top.sv */
// Biquad coefficient subsystem top
`timescale 1ns/10ps
`default_nettype none

module lpf_coef_top
    import lpf_pkg::*;
#(
    parameter int QUEUE_DEPTH = 4,
    parameter int OUT_CREDITS = 2
) (
    input  logic  clk,
    input  logic  reset,
    // Upstream request side
    input  logic  req_valid,
    input  word_t omega0,
    input  word_t inv_2q,
    output logic  req_credit,
    // Downstream coefficient side
    input  logic  coef_credit,
    output logic  coef_valid,
    output word_t b0,
    output word_t b1,
    output word_t b2,
    output word_t a0,
    output word_t a1,
    output word_t a2
);

    logic  q_empty;
    logic  q_pop;
    word_t head_omega0;
    word_t head_inv_2q;

    coef_bus_if coef_bus ();

    // Every req_valid is one queued request
    calc_request_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) u_queue (
        .clk         (clk),
        .reset       (reset),
        .push        (req_valid),
        .push_omega0 (omega0),
        .push_inv_2q (inv_2q),
        .pop         (q_pop),
        .empty       (q_empty),
        .head_omega0 (head_omega0),
        .head_inv_2q (head_inv_2q),
        .credit      (req_credit)
    );

    lpf_coef_engine u_engine (
        .clk    (clk),
        .reset  (reset),
        .empty  (q_empty),
        .omega0 (head_omega0),
        .inv_2q (head_inv_2q),
        .pop    (q_pop),
        .coefs  (coef_bus.engine)
    );

    coef_credit_sender #(
        .OUT_CREDITS (OUT_CREDITS)
    ) u_sender (
        .clk         (clk),
        .reset       (reset),
        .coefs       (coef_bus.sender),
        .coef_credit (coef_credit),
        .coef_valid  (coef_valid),
        .b0          (b0),
        .b1          (b1),
        .b2          (b2),
        .a0          (a0),
        .a1          (a1),
        .a2          (a2)
    );

endmodule

`default_nettype wire

/* tests/lpf_coef_checker.sv */
// Credit and reset assertions
`timescale 1ns/10ps
`default_nettype none

module lpf_coef_checker
    import lpf_pkg::*;
#(
    parameter int QUEUE_DEPTH = 4,
    parameter int OUT_CREDITS = 2
) (
    input wire logic  clk,
    input wire logic  reset,
    input wire logic  req_valid,
    input wire logic  req_credit,
    input wire logic  coef_valid,
    input wire logic  coef_credit,
    input wire word_t b0,
    input wire word_t b1,
    input wire word_t b2,
    input wire word_t a0,
    input wire word_t a1,
    input wire word_t a2
);

    // Output credit and queue fill models
    int out_cred;
    int level;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            out_cred <= OUT_CREDITS;
            level    <= 0;
        end else begin
            if (coef_valid && !coef_credit) begin
                out_cred <= out_cred - 1;
            end else if (!coef_valid && coef_credit && out_cred < OUT_CREDITS) begin
                out_cred <= out_cred + 1;
            end
            // Credit pulse marks a freed slot
            level <= level + (req_valid ? 1 : 0) - (req_credit ? 1 : 0);
        end
    end

    a_send_needs_credit: assert property (@(posedge clk) disable iff (reset)
        coef_valid |-> out_cred > 0)
        else $error("coefficient set sent without output credit");

    a_no_push_when_full: assert property (@(posedge clk) disable iff (reset)
        req_valid |-> level < QUEUE_DEPTH)
        else $error("request pushed into a full queue");

    a_quiet_in_reset: assert property (@(posedge clk)
        reset |-> (!coef_valid && !req_credit))
        else $error("output active during reset");

    a_known_coefs: assert property (@(posedge clk) disable iff (reset)
        coef_valid |-> !$isunknown({b0, b1, b2, a0, a1, a2}))
        else $error("unknown coefficient while valid");

endmodule

bind lpf_coef_top lpf_coef_checker #(
    .QUEUE_DEPTH (QUEUE_DEPTH),
    .OUT_CREDITS (OUT_CREDITS)
) u_checker (
    .clk         (clk),
    .reset       (reset),
    .req_valid   (req_valid),
    .req_credit  (req_credit),
    .coef_valid  (coef_valid),
    .coef_credit (coef_credit),
    .b0          (b0),
    .b1          (b1),
    .b2          (b2),
    .a0          (a0),
    .a1          (a1),
    .a2          (a2)
);

`default_nettype wire

/* tests/lpf_coef_tb.sv */
// Biquad coefficient subsystem testbench
`timescale 1ns/10ps
`default_nettype none

module lpf_coef_tb;
    import lpf_pkg::*;

    localparam int QUEUE_DEPTH = 4;
    localparam int OUT_CREDITS = 2;
    localparam int RESET_CYCLES = 16;
    localparam int MAX_CASES = 16;

    logic  clk;
    logic  reset;
    logic  req_valid;
    word_t omega0;
    word_t inv_2q;
    logic  req_credit;
    logic  coef_credit;
    logic  coef_valid;
    word_t b0, b1, b2, a0, a1, a2;

    // Case table, one row per line of the cases file
    int n_cases;
    int c_omega [MAX_CASES];
    int c_inv [MAX_CASES];
    int c_coef [MAX_CASES][6];

    // Scoreboard and handshake bookkeeping
    int expect_q[$];
    int due_q[$];
    int sent;
    int credits_back;
    int recv;
    int errors;
    int checks;
    int cycle;
    int tests_run;
    bit credit_hold;
    bit rand_delay;
    integer seed = 44;

    lpf_coef_top #(
        .QUEUE_DEPTH (QUEUE_DEPTH),
        .OUT_CREDITS (OUT_CREDITS)
    ) u_dut (
        .clk (clk), .reset (reset),
        .req_valid (req_valid), .omega0 (omega0), .inv_2q (inv_2q),
        .req_credit (req_credit), .coef_credit (coef_credit),
        .coef_valid (coef_valid),
        .b0 (b0), .b1 (b1), .b2 (b2), .a0 (a0), .a1 (a1), .a2 (a2)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic check_value(input string name, input int expected, input int actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("MISMATCH t=%0t %s expected %0d actual %0d", $time, name, expected,
                actual);
        end
    endtask

    // ----------------------------------------------------------------------
    // Monitor and credit return, both on the falling edge
    // ----------------------------------------------------------------------
    always @(negedge clk) begin
        int idx;
        int delay;
        cycle++;
        if (req_credit) begin
            credits_back++;
        end
        if (coef_valid) begin
            recv++;
            if (expect_q.size() == 0) begin
                errors++;
                $display("Unexpected coefficient set at %0t", $time);
            end else begin
                idx = expect_q.pop_front();
                check_value("b0", c_coef[idx][0], int'(b0));
                check_value("b1", c_coef[idx][1], int'(b1));
                check_value("b2", c_coef[idx][2], int'(b2));
                check_value("a0", c_coef[idx][3], int'(a0));
                check_value("a1", c_coef[idx][4], int'(a1));
                check_value("a2", c_coef[idx][5], int'(a2));
                check_value("b2 against b0", c_coef[idx][0], int'(b2));
            end
            delay = rand_delay ? (($random(seed) & 15) + 1) : 1;
            due_q.push_back(cycle + delay);
        end
        // One credit per pulse, oldest first
        if (!credit_hold && due_q.size() > 0 && due_q[0] <= cycle) begin
            void'(due_q.pop_front());
            coef_credit <= 1'b1;
        end else begin
            coef_credit <= 1'b0;
        end
    end

    // Waits for upstream credit, then pushes one request
    task automatic send_request(input int idx);
        while (sent - credits_back >= QUEUE_DEPTH) @(negedge clk);
        req_valid = 1'b1;
        omega0    = word_t'(c_omega[idx]);
        inv_2q    = word_t'(c_inv[idx]);
        expect_q.push_back(idx);
        sent++;
        @(negedge clk);
        req_valid = 1'b0;
    endtask

    task automatic wait_received(input int target, input int limit);
        int n;
        n = 0;
        while (recv < target && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (recv < target) begin
            errors++;
            $display("Timed out waiting for set %0d at %0t", target, $time);
        end
    endtask

    task automatic report_test(input string name, input int err_before);
        tests_run++;
        $display("test %0d %s: %s", tests_run, name,
            (errors == err_before) ? "ok" : "FAILED");
    endtask

    task automatic load_cases();
        int fd;
        int code;
        int v [8];
        string line;
        fd = $fopen("tests/lpf_cases.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the cases file");
        end else begin
            while (!$feof(fd) && n_cases < MAX_CASES) begin
                code = $fgets(line, fd);
                // Skip comments and blank lines
                if (code > 0 && line.len() > 2 && line[0] != 8'h23) begin
                    code = $sscanf(line, "%d %d %d %d %d %d %d %d",
                        v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7]);
                    if (code == 8) begin
                        c_omega[n_cases] = v[0];
                        c_inv[n_cases]   = v[1];
                        for (int k = 0; k < 6; k++) c_coef[n_cases][k] = v[k + 2];
                        n_cases++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // Watchdog sized from the number of requests issued
    initial begin
        int total;
        wait (n_cases > 0);
        total = 3 * n_cases + 2 * QUEUE_DEPTH;
        repeat (total * 200 + RESET_CYCLES) @(posedge clk);
        $display("Watchdog expired before all tests completed");
        $display("Test failed");
        $finish;
    end

    // ----------------------------------------------------------------------
    // Test sequence
    // ----------------------------------------------------------------------
    task automatic run_tests();
        int e0;
        int base;
        repeat (RESET_CYCLES) @(negedge clk);
        reset = 1'b0;

        // Quiet outputs before any request
        e0 = errors;
        repeat (20) @(negedge clk);
        check_value("coef_valid pulses", 0, recv);
        check_value("req_credit pulses", 0, credits_back);
        report_test("idle after reset", e0);

        // Each case alone
        e0 = errors;
        for (int i = 0; i < n_cases; i++) begin
            send_request(i);
            wait_received(recv + 1, 200);
        end
        report_test("single cases", e0);

        // Back to back up to queue depth
        e0 = errors;
        base = recv;
        for (int i = 0; i < QUEUE_DEPTH; i++) send_request(i % n_cases);
        wait_received(base + QUEUE_DEPTH, 200 * QUEUE_DEPTH);
        check_value("req_credit total", sent, credits_back);
        report_test("back to back", e0);

        // Withheld output credit
        e0 = errors;
        while (due_q.size() > 0) @(negedge clk);
        @(negedge clk);
        credit_hold = 1'b1;
        base = recv;
        for (int i = 0; i < QUEUE_DEPTH; i++) send_request((i + 1) % n_cases);
        wait_received(base + OUT_CREDITS, 200 * OUT_CREDITS);
        repeat (200) @(negedge clk);
        check_value("sets without credit", OUT_CREDITS, recv - base);
        credit_hold = 1'b0;
        wait_received(base + QUEUE_DEPTH, 200 * QUEUE_DEPTH);
        report_test("withheld credit", e0);

        // Random gaps on both sides
        e0 = errors;
        rand_delay = 1'b1;
        base = recv;
        for (int i = 0; i < 2 * n_cases; i++) begin
            repeat ($random(seed) & 7) @(negedge clk);
            send_request(i % n_cases);
        end
        wait_received(base + 2 * n_cases, 200 * n_cases);
        check_value("sets left over", 0, expect_q.size());
        report_test("random gaps", e0);

        $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    endtask

    initial begin
        reset = 1'b1;
        req_valid = 1'b0;
        omega0 = '0;
        inv_2q = '0;
        coef_credit = 1'b0;
        credit_hold = 1'b0;
        rand_delay = 1'b0;
        load_cases();
        if (n_cases == 0) begin
            $display("No usable case lines were read from the cases file");
            $display("Test failed");
            $finish;
        end else begin
            run_tests();
        end
    end

endmodule

`default_nettype wire

/* list.f */
src/lpf_pkg.sv
src/dsp_bus_if.sv
src/coef_bus_if.sv
src/calc_request_queue.sv
src/mac_slice.sv
src/taylor_trig.sv
src/lpf_coef_engine.sv
src/coef_credit_sender.sv
src/lpf_coef_top.sv
tests/lpf_coef_checker.sv
tests/lpf_coef_tb.sv

/* run.sh */
#!/bin/sh
# Build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f list.f --top-module lpf_coef_tb -o lpf_sim &&
./obj_dir/lpf_sim | tee /dev/stderr | grep -q "Test passed" &&
echo "simulation PASS" ||
{ echo "simulation FAIL"; exit 1; }

/* tests/lpf_cases.txt */
# omega0 inv_2q b0 b1 b2 a0 a1 a2
# decimal Q2.16 words, expected values from the slice rule
0 32768 0 0 0 65536 -131072 65536
65536 32768 15018 30037 15018 93115 -70998 37957
32768 65536 4011 8022 4011 96955 -115028 34117
81920 16384 22266 44533 22266 81098 -42006 49974
16384 131071 1019 2038 1019 97961 -126996 33111
49152 46341 8784 17568 8784 97124 -95936 33948
